//--- all.f
+incdir+design
design/cnn_reg_pkg.sv
design/cnn_conv_pkg.sv
design/cnn_apb_ctrl.sv
design/cnn_buffer_ram.sv
design/cnn_conv2d.sv
design/cnn_top.sv
tb/cnn_sva.sv
tb/cnn_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the cnn testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module cnn_tb -o cnn_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/cnn_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "All tests passed" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- tb/cnn_tb.sv
`include "cnn_config.svh"

module cnn_tb;
   import cnn_reg_pkg::*;

   localparam int N_RUNS    = 7;
   localparam int ENG_WORST = 3 * 10 * 10 * 12 + 20;   // 12 cycles per output
   localparam int BUS_WORST = 6 * 500;                 // 500 accesses per run at 6 cycles
   localparam int WDOG_TIME = 20 * (N_RUNS * (ENG_WORST + BUS_WORST) + 4000);

   logic        PCLK = 1'b0;
   logic        rstn;
   logic        psel;
   logic        pwrite;
   logic        penable;
   logic [6:0]  paddr;
   logic [31:0] pwdata;
   logic        r_sda;
   logic        r_scl;
   logic        pready;
   logic [31:0] prdata;
   logic        sda;
   logic        scl;
   logic [7:0]  debug_mux;
   logic        intr;

   logic [31:0] pix_mem  [`CNN_PIX_DEPTH];
   logic [31:0] coef_mem [`CNN_COEF_DEPTH];
   int          c_w;
   int          c_h;
   int          c_nf;
   int          c_pix_base;
   int          c_filt_base;
   int          c_bias_base;
   int          c_res_base;
   int unsigned c_scale;
   int unsigned c_shift;

   cnn_top i_cnn_top (
      .PCLK             (PCLK),
      .rstn             (rstn),
      .i_psel           (psel),
      .i_pwrite         (pwrite),
      .i_penable        (penable),
      .i_paddr          (paddr),
      .i_pwdata         (pwdata),
      .i_r_sda          (r_sda),
      .i_r_scl          (r_scl),
      .o_pready         (pready),
      .o_prdata         (prdata),
      .o_sda            (sda),
      .o_scl            (scl),
      .o_debug_mux      (debug_mux),
      .o_conv_done_intr (intr)
   );

   always #10 PCLK = ~PCLK;

   initial begin
      #(WDOG_TIME);
      $display("watchdog expired before the test sequence finished");
      $display("Some tests failed");
      $fatal(1, "timeout");
   end

   task automatic report_mismatch(input string msg);
      $display("** Error at %0t: %s", $time, msg);
      $display("Some tests failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_hang(input string msg);
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1, "stopped on a hang");
   endtask

   task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
      end
   endtask

   task automatic check_quant(input string what, input quant_word_u got, input quant_word_u exp);
      if (got.raw !== exp.raw) begin
         report_mismatch($sformatf("%s: got scale %h shift %0d, expected scale %h shift %0d",
                                   what, got.fld.scale, got.fld.shift,
                                   exp.fld.scale, exp.fld.shift));
      end
   endtask

   task automatic check_result(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
      end
   endtask

   task automatic bus_write(input logic [6:0] addr, input logic [31:0] data);
      int n;
      n = 0;
      @(posedge PCLK);
      #2;
      psel   = 1'b1;
      pwrite = 1'b1;
      paddr  = addr;
      pwdata = data;
      @(posedge PCLK);
      #2;
      penable = 1'b1;
      while (pready !== 1'b1) begin
         if (n == 8) report_hang("no pready on a bus write");
         @(posedge PCLK);
         #2;
         n++;
      end
      @(posedge PCLK);                 // register updates on this edge
      #2;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic bus_read(input logic [6:0] addr, output logic [31:0] data);
      int n;
      n = 0;
      @(posedge PCLK);
      #2;
      psel   = 1'b1;
      pwrite = 1'b0;
      paddr  = addr;
      @(posedge PCLK);
      #2;
      penable = 1'b1;
      while (pready !== 1'b1) begin
         if (n == 8) report_hang("no pready on a bus read");
         @(posedge PCLK);
         #2;
         n++;
      end
      data    = prdata;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   function automatic logic [31:0] reg_mask(input int addr);
      case (addr)
         1, 2, 3, 4:     return 32'h1ff;
         5, 6, 7, 8, 12: return 32'hfff;
         9:              return 32'hffff;
         10, 11:         return 32'h1;
         default:        return 32'hff;   // debug selector
      endcase
   endfunction

   // one output pixel from the convolution rule
   function automatic logic [7:0] model_pixel(input int f, input int y, input int x);
      longint acc;
      longint scaled;
      acc = longint'($signed(coef_mem[c_bias_base + f]));
      for (int i = 0; i < 3; i++) begin
         for (int j = 0; j < 3; j++) begin
            acc += longint'(pix_mem[c_pix_base + (y + i) * c_w + x + j][7:0]) *
                   longint'($signed(coef_mem[c_filt_base + 9 * f + 3 * i + j][7:0]));
         end
      end
      scaled = (acc * longint'(c_scale)) >>> (`CNN_QFRAC + c_shift);
      if (scaled < 0) return 8'd0;
      else if (scaled > 255) return 8'd255;
      else return scaled[7:0];
   endfunction

   task automatic load_case();
      logic [31:0] word;
      quant_word_u q;
      c_w         = $urandom_range(3, 12);
      c_h         = $urandom_range(3, 12);
      c_nf        = $urandom_range(1, 3);
      c_pix_base  = $urandom_range(0, 1500);
      c_filt_base = $urandom_range(0, 1500);
      c_bias_base = $urandom_range(2000, 2500);   // after the weights
      c_res_base  = $urandom_range(0, 3500);
      c_scale     = $urandom_range(16'h0200, 16'h4000);
      c_shift     = $urandom_range(0, 7);
      bus_write(7'h0c, c_pix_base);
      for (int i = 0; i < c_w * c_h; i++) begin
         word                   = $urandom;
         pix_mem[c_pix_base + i] = word;
         bus_write(7'h0d, word);
      end
      bus_write(7'h0c, c_filt_base);
      for (int i = 0; i < 9 * c_nf; i++) begin
         word                    = $urandom;
         coef_mem[c_filt_base + i] = word;
         bus_write(7'h0e, word);
      end
      bus_write(7'h0c, c_bias_base);
      for (int i = 0; i < c_nf; i++) begin
         word                     = 32'(int'($urandom_range(0, 40000)) - 20000);
         coef_mem[c_bias_base + i] = word;
         bus_write(7'h0e, word);
      end
      q.raw       = '0;
      q.fld.scale = 16'(c_scale);
      q.fld.shift = 3'(c_shift);
      bus_write(7'h01, c_w);
      bus_write(7'h02, c_h);
      bus_write(7'h03, 32'h1);
      bus_write(7'h04, c_nf);
      bus_write(7'h05, c_filt_base);
      bus_write(7'h06, c_pix_base);
      bus_write(7'h07, c_bias_base);
      bus_write(7'h08, c_res_base);
      bus_write(7'h09, (c_w - 2) * (c_h - 2) * c_nf);
      bus_write(7'h12, q.raw);
   endtask

   task automatic run_engine();
      int n;
      n = 0;
      bus_write(7'h00, 32'h1);
      while (intr !== 1'b1) begin
         if (n == ENG_WORST) report_hang("no interrupt from the engine");
         @(posedge PCLK);
         #2;
         n++;
      end
      bus_write(7'h0b, 32'h0);
   endtask

   task automatic check_results();
      logic [31:0] got;
      bus_write(7'h0c, c_res_base);
      for (int f = 0; f < c_nf; f++) begin
         for (int y = 0; y < c_h - 2; y++) begin
            for (int x = 0; x < c_w - 2; x++) begin
               bus_read(7'h0f, got);
               check_result($sformatf("result f%0d y%0d x%0d", f, y, x), got[7:0],
                            model_pixel(f, y, x));
            end
         end
      end
   endtask

   initial begin
      logic [31:0] rd;
      logic [31:0] rd2;
      logic [31:0] wr;
      logic [31:0] base;
      logic [31:0] pwin [8];
      logic [31:0] cwin [8];
      quant_word_u q;
      logic [1:0]  pins;
      int          n;

      void'($urandom(32'h977cae80));
      rstn    = 1'b0;
      psel    = 1'b0;
      pwrite  = 1'b0;
      penable = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      r_sda   = 1'b0;
      r_scl   = 1'b1;
      repeat (4) @(posedge PCLK);
      #2;
      rstn = 1'b1;

      q.raw       = '0;
      q.fld.scale = 16'h4000;
      q.fld.shift = 3'd2;
      bus_read(7'h12, rd);
      check_quant("quantizer after reset", rd, q);
      bus_read(7'h10, rd);
      check_word("debug selector after reset", rd, 32'h1);
      check_word("debug port after reset", 32'(debug_mux), 32'h1);
      bus_read(7'h13, rd);
      check_word("serial bits after reset", rd, 32'he);   // sda and scl high
      check_word("o_sda after reset", 32'(sda), 32'h1);
      check_word("o_scl after reset", 32'(scl), 32'h1);

      bus_write(7'h00, 32'h2);
      bus_read(7'h00, rd);
      check_word("control incontrol bit", rd, 32'h2);
      for (int a = 1; a <= 16; a++) begin
         if (a == 13 || a == 14 || a == 15) continue;
         wr = $urandom;
         bus_write(7'(a), wr);
         bus_read(7'(a), rd);
         check_word($sformatf("register %0h", a), rd, wr & reg_mask(a));
         if (a == 16) begin
            check_word("debug port after write", 32'(debug_mux), wr & 32'hff);
         end
      end
      bus_write(7'h00, 32'h0);
      bus_write(7'h0a, 32'h0);
      bus_write(7'h0b, 32'h0);

      base = $urandom_range(0, 4000);
      bus_write(7'h0c, base);
      for (int i = 0; i < 8; i++) begin
         pwin[i] = $urandom;
         bus_write(7'h0d, pwin[i]);
      end
      bus_write(7'h0c, base);
      for (int i = 0; i < 8; i++) begin
         cwin[i] = $urandom;
         bus_write(7'h0e, cwin[i]);
      end
      bus_read(7'h0c, rd);
      check_word("pointer after window writes", rd, base + 8);
      bus_write(7'h0c, base);
      for (int i = 0; i < 8; i++) begin
         bus_read(7'h0d, rd);
         check_word($sformatf("pixel window word %0d", i), rd, pwin[i]);
      end
      bus_read(7'h0c, rd);
      check_word("pointer after window reads", rd, base + 8);
      bus_write(7'h0c, base);
      for (int i = 0; i < 8; i++) begin
         bus_read(7'h0e, rd);
         check_word($sformatf("coefficient window word %0d", i), rd, cwin[i]);
      end

      bus_write(7'h0a, 32'h1);
      repeat (4) begin
         load_case();
         run_engine();
         check_results();
      end

      // status without enable
      bus_write(7'h0a, 32'h0);
      load_case();
      bus_write(7'h00, 32'h1);
      n  = 0;
      rd = '0;
      while (rd[0] !== 1'b1) begin
         if (n == ENG_WORST) report_hang("interrupt status never set");
         bus_read(7'h0b, rd);
         n++;
      end
      check_word("interrupt output while disabled", 32'(intr), 32'h0);
      bus_read(7'h00, rd);
      check_word("start after done", rd, 32'h0);
      bus_write(7'h0a, 32'h1);
      check_word("interrupt output once enabled", 32'(intr), 32'h1);
      bus_write(7'h0b, 32'h0);
      check_word("interrupt output after clear", 32'(intr), 32'h0);
      check_results();

      wr = $urandom;
      bus_write(7'h12, wr);
      bus_read(7'h12, rd);
      q.raw = wr & 32'h7ffff;
      check_quant("quantizer raw write", rd, q);
      load_case();
      run_engine();
      check_results();
      c_shift     = (c_shift + 3) % 8;
      q.raw       = '0;
      q.fld.scale = 16'(c_scale);
      q.fld.shift = 3'(c_shift);
      bus_write(7'h12, q.raw);
      bus_read(7'h12, rd);
      check_quant("quantizer shift change", rd, q);
      run_engine();                     // same buffers with a new shift
      check_results();

      bus_read(7'h11, rd);
      bus_read(7'h11, rd2);
      if (rd == 32'h0) report_mismatch("cycle counter is zero after a run");
      check_word("cycle counter after done", rd2, rd);

      repeat (4) begin
         pins = 2'($urandom);
         bus_write(7'h13, {30'h0, pins});
         check_word("o_sda", 32'(sda), 32'(pins[0]));
         check_word("o_scl", 32'(scl), 32'(pins[1]));
         r_sda = 1'($urandom);
         r_scl = 1'($urandom);
         bus_read(7'h13, rd);
         check_word("serial readback", rd, {28'h0, pins, r_scl, r_sda});
      end

      $display("All tests passed");
      $finish;
   end

endmodule

//--- tb/cnn_sva.sv
module cnn_sva (
   input logic PCLK,
   input logic rstn,
   input logic i_pwrite,
   input logic i_pready,
   input logic i_start,
   input logic i_done,
   input logic i_pix_we,
   input logic i_coef_we
);

   a_pready_single: assert property (@(posedge PCLK) disable iff (!rstn)
      i_pready && i_pwrite |=> !i_pready)
      else $error("pready held high after a write response");

   a_done_in_run: assert property (@(posedge PCLK) disable iff (!rstn)
      i_done |-> i_start)
      else $error("engine done outside a run");

   // only one window can be written per transfer
   a_one_window: assert property (@(posedge PCLK) disable iff (!rstn)
      !(i_pix_we && i_coef_we))
      else $error("pixel and coefficient writes in the same cycle");

endmodule

bind cnn_top cnn_sva i_cnn_sva (
   .PCLK      (PCLK),
   .rstn      (rstn),
   .i_pwrite  (i_pwrite),
   .i_pready  (o_pready),
   .i_start   (start),
   .i_done    (done),
   .i_pix_we  (pix_wr.we),
   .i_coef_we (coef_wr.we)
);

//--- design/cnn_top.sv
`include "cnn_config.svh"

module cnn_top (
   input  logic        PCLK,
   input  logic        rstn,
   input  logic        i_psel,
   input  logic        i_pwrite,
   input  logic        i_penable,
   input  logic [6:0]  i_paddr,
   input  logic [31:0] i_pwdata,
   input  logic        i_r_sda,
   input  logic        i_r_scl,
   output logic        o_pready,
   output logic [31:0] o_prdata,
   output logic        o_sda,
   output logic        o_scl,
   output logic [7:0]  o_debug_mux,
   output logic        o_conv_done_intr
);
   import cnn_reg_pkg::*;
   import cnn_conv_pkg::*;

   buf_wr_t                pix_wr;
   buf_wr_t                coef_wr;
   conv_cfg_t              cfg;
   eng_rd_t                pix_rd;
   eng_rd_t                coef_rd;
   res_wr_t                res_wr;
   logic [`CNN_ADDR_W-1:0] host_raddr;
   logic [31:0]            pix_rdata_host;
   logic [31:0]            pix_rdata_eng;
   logic [31:0]            coef_rdata_host;
   logic [31:0]            coef_rdata_eng;
   logic [31:0]            res_rdata;
   logic                   start;
   logic                   done;

   cnn_apb_ctrl u_ctrl (
      .PCLK             (PCLK),
      .rstn             (rstn),
      .i_psel           (i_psel),
      .i_pwrite         (i_pwrite),
      .i_penable        (i_penable),
      .i_paddr          (i_paddr),
      .i_pwdata         (i_pwdata),
      .i_r_sda          (i_r_sda),
      .i_r_scl          (i_r_scl),
      .i_done           (done),
      .i_pix_rdata      (pix_rdata_host),
      .i_coef_rdata     (coef_rdata_host),
      .i_res_rdata      (res_rdata),
      .o_pready         (o_pready),
      .o_prdata         (o_prdata),
      .o_pix_wr         (pix_wr),
      .o_coef_wr        (coef_wr),
      .o_host_raddr     (host_raddr),
      .o_cfg            (cfg),
      .o_start          (start),
      .o_incontrol      (),
      .o_debug_mux      (o_debug_mux),
      .o_conv_done_intr (o_conv_done_intr),
      .o_sda            (o_sda),
      .o_scl            (o_scl)
   );

   cnn_buffer_ram #(.DEPTH(`CNN_PIX_DEPTH)) u_pix_buf (
      .PCLK      (PCLK),
      .i_we      (pix_wr.we),
      .i_waddr   (pix_wr.addr),
      .i_wdata   (pix_wr.data),
      .i_raddr_a (host_raddr),
      .i_raddr_b (pix_rd.addr),
      .o_rdata_a (pix_rdata_host),
      .o_rdata_b (pix_rdata_eng)
   );

   cnn_buffer_ram #(.DEPTH(`CNN_COEF_DEPTH)) u_coef_buf (
      .PCLK      (PCLK),
      .i_we      (coef_wr.we),
      .i_waddr   (coef_wr.addr),
      .i_wdata   (coef_wr.data),
      .i_raddr_a (host_raddr),
      .i_raddr_b (coef_rd.addr),
      .o_rdata_a (coef_rdata_host),
      .o_rdata_b (coef_rdata_eng)
   );

   // results come only from the engine
   cnn_buffer_ram #(.DEPTH(`CNN_RES_DEPTH)) u_res_buf (
      .PCLK      (PCLK),
      .i_we      (res_wr.we),
      .i_waddr   (res_wr.addr),
      .i_wdata   ({24'h0, res_wr.data}),
      .i_raddr_a (host_raddr),
      .i_raddr_b ('0),
      .o_rdata_a (res_rdata),
      .o_rdata_b ()
   );

   cnn_conv2d u_conv (
      .PCLK         (PCLK),
      .rstn         (rstn),
      .i_start      (start),
      .i_cfg        (cfg),
      .i_pix_rdata  (pix_rdata_eng),
      .i_coef_rdata (coef_rdata_eng),
      .o_pix_rd     (pix_rd),
      .o_coef_rd    (coef_rd),
      .o_res_wr     (res_wr),
      .o_done       (done)
   );

endmodule

//--- design/cnn_conv2d.sv
`include "cnn_config.svh"

module cnn_conv2d (
   input  logic                    PCLK,
   input  logic                    rstn,
   input  logic                    i_start,
   input  cnn_conv_pkg::conv_cfg_t i_cfg,
   input  logic [31:0]             i_pix_rdata,
   input  logic [31:0]             i_coef_rdata,
   output cnn_conv_pkg::eng_rd_t   o_pix_rd,
   output cnn_conv_pkg::eng_rd_t   o_coef_rd,
   output cnn_conv_pkg::res_wr_t   o_res_wr,
   output logic                    o_done
);

   localparam int AW = `CNN_ADDR_W;

   typedef enum logic [2:0] {
      st_idle,
      st_bias,
      st_mac,
      st_drain,
      st_write,
      st_done
   } state_t;

   state_t              state;
   logic [8:0]          f;
   logic [8:0]          y;
   logic [8:0]          x;
   logic [1:0]          kr;          // kernel row
   logic [1:0]          kc;          // kernel column
   logic [AW-1:0]       res_idx;     // f*ow*oh + y*ow + x
   logic                bias_vld;
   logic                tap_vld;
   logic signed [31:0]  acc;
   logic [8:0]          ow;
   logic [8:0]          oh;
   logic                last_x;
   logic                last_y;
   logic                last_f;
   logic [AW-1:0]       pix_addr;
   logic [AW-1:0]       coef_addr;
   logic [AW-1:0]       bias_addr;
   logic signed [48:0]  prod;
   logic signed [48:0]  scaled;
   logic [7:0]          q8;

   assign ow     = i_cfg.width - 9'd2;
   assign oh     = i_cfg.height - 9'd2;
   assign last_x = (x == ow - 9'd1);
   assign last_y = (y == oh - 9'd1);
   assign last_f = (f == i_cfg.filters - 9'd1);

   assign pix_addr  = i_cfg.pixel_base + (y + kr) * i_cfg.width + x + kc;
   assign coef_addr = i_cfg.filter_base + f * 4'd9 + kr * 2'd3 + kc;
   assign bias_addr = i_cfg.bias_base + f;

   // quantize then clamp to 0..255
   assign prod   = acc * $signed({1'b0, i_cfg.scale});
   assign scaled = prod >>> (`CNN_QFRAC + i_cfg.shift);
   assign q8     = scaled[48] ? 8'd0 : ((|scaled[47:8]) ? 8'hff : scaled[7:0]);

   always_comb begin
      o_pix_rd.re    = (state == st_mac);
      o_pix_rd.addr  = pix_addr;
      o_coef_rd.re   = (state == st_bias) || (state == st_mac);
      o_coef_rd.addr = (state == st_bias) ? bias_addr : coef_addr;   // bias shares the port
   end

   // read data lands one cycle after the request
   always_ff @(posedge PCLK) begin
      if (bias_vld) begin
         acc <= $signed(i_coef_rdata);
      end else if (tap_vld) begin
         acc <= acc + $signed({1'b0, i_pix_rdata[7:0]}) * $signed(i_coef_rdata[7:0]);
      end
   end

   always_ff @(posedge PCLK or negedge rstn) begin
      if (!rstn) begin
         state    <= st_idle;
         f        <= '0;
         y        <= '0;
         x        <= '0;
         kr       <= '0;
         kc       <= '0;
         res_idx  <= '0;
         bias_vld <= 1'b0;
         tap_vld  <= 1'b0;
         o_res_wr <= '0;
         o_done   <= 1'b0;
      end else begin
         bias_vld    <= (state == st_bias);
         tap_vld     <= (state == st_mac);
         o_res_wr.we <= 1'b0;
         o_done      <= 1'b0;
         if (!i_start) begin
            state <= st_idle;          // start dropped, abort
         end else begin
            case (state)
               st_idle: begin
                  f       <= '0;
                  y       <= '0;
                  x       <= '0;
                  kr      <= '0;
                  kc      <= '0;
                  res_idx <= '0;
                  state   <= st_bias;
               end
               st_bias: state <= st_mac;
               st_mac: begin
                  kc <= kc + 2'd1;
                  if (kc == 2'd2) begin
                     kc <= '0;
                     kr <= kr + 2'd1;
                     if (kr == 2'd2) begin
                        kr    <= '0;
                        state <= st_drain;
                     end
                  end
               end
               st_drain: state <= st_write;   // last product still in flight
               st_write: begin
                  o_res_wr <= '{we: 1'b1, addr: i_cfg.result_base + res_idx, data: q8};
                  res_idx  <= res_idx + 1'b1;
                  x        <= x + 9'd1;
                  state    <= st_bias;
                  if (last_x) begin
                     x <= '0;
                     y <= y + 9'd1;
                     if (last_y) begin
                        y <= '0;
                        f <= f + 9'd1;
                        if (last_f) begin
                           state  <= st_done;
                           o_done <= 1'b1;
                        end
                     end
                  end
               end
               st_done: ;                     // wait for start to clear
               default: state <= st_idle;
            endcase
         end
      end
   end

endmodule

//--- design/cnn_buffer_ram.sv
module cnn_buffer_ram #(
   parameter int  DEPTH = 4096,
   localparam int AW    = $clog2(DEPTH)
) (
   input  logic          PCLK,
   input  logic          i_we,
   input  logic [AW-1:0] i_waddr,
   input  logic [31:0]   i_wdata,
   input  logic [AW-1:0] i_raddr_a,
   input  logic [AW-1:0] i_raddr_b,
   output logic [31:0]   o_rdata_a,
   output logic [31:0]   o_rdata_b
);

   logic [31:0] mem [DEPTH];

   always_ff @(posedge PCLK) begin
      if (i_we) begin
         mem[i_waddr] <= i_wdata;
      end
      o_rdata_a <= mem[i_raddr_a];   // host port
      o_rdata_b <= mem[i_raddr_b];   // engine port
   end

endmodule

//--- design/cnn_apb_ctrl.sv
`include "cnn_config.svh"

module cnn_apb_ctrl (
   input  logic                    PCLK,
   input  logic                    rstn,
   input  logic                    i_psel,
   input  logic                    i_pwrite,
   input  logic                    i_penable,
   input  logic [6:0]              i_paddr,
   input  logic [31:0]             i_pwdata,
   input  logic                    i_r_sda,
   input  logic                    i_r_scl,
   input  logic                    i_done,
   input  logic [31:0]             i_pix_rdata,
   input  logic [31:0]             i_coef_rdata,
   input  logic [31:0]             i_res_rdata,
   output logic                    o_pready,
   output logic [31:0]             o_prdata,
   output cnn_reg_pkg::buf_wr_t    o_pix_wr,
   output cnn_reg_pkg::buf_wr_t    o_coef_wr,
   output logic [`CNN_ADDR_W-1:0]  o_host_raddr,
   output cnn_conv_pkg::conv_cfg_t o_cfg,
   output logic                    o_start,
   output logic                    o_incontrol,
   output logic [7:0]              o_debug_mux,
   output logic                    o_conv_done_intr,
   output logic                    o_sda,
   output logic                    o_scl
);
   import cnn_reg_pkg::*;

   localparam int AW = `CNN_ADDR_W;

   typedef enum logic [1:0] {st_idle, st_write, st_read, st_wait} state_t;

   state_t          state;
   reg_file_t       regs;
   logic [AW-1:0]   ptr;      // window pointer
   logic [23:0]     cycles;
   logic            start_q;

   assign o_host_raddr     = ptr;
   assign o_start          = regs.start;
   assign o_incontrol      = regs.incontrol;
   assign o_debug_mux      = regs.debug_mux;
   assign o_conv_done_intr = regs.intr_en & regs.intr_sts;
   assign o_sda            = regs.sda;
   assign o_scl            = regs.scl;

   assign o_cfg = '{
      width:       regs.width,
      height:      regs.height,
      filters:     regs.filters,
      filter_base: regs.filter_base,
      pixel_base:  regs.pixel_base,
      bias_base:   regs.bias_base,
      result_base: regs.result_base,
      scale:       regs.quant.fld.scale,
      shift:       regs.quant.fld.shift
   };

   always_ff @(posedge PCLK or negedge rstn) begin
      if (!rstn) begin
         state          <= st_idle;
         regs           <= '0;
         regs.debug_mux <= 8'h1;
         regs.quant.raw <= 32'h0002_4000;   // scale 0x4000, shift 2
         regs.sda       <= 1'b1;
         regs.scl       <= 1'b1;
         ptr            <= '0;
         cycles         <= '0;
         start_q        <= 1'b0;
         o_pready       <= 1'b0;
         o_prdata       <= '0;
         o_pix_wr       <= '0;
         o_coef_wr      <= '0;
      end else begin
         start_q <= regs.start;
         if (regs.start && !start_q) begin
            cycles <= '0;                   // new run
         end else if (regs.start) begin
            cycles <= cycles + 24'd1;
         end

         o_pix_wr.we  <= 1'b0;
         o_coef_wr.we <= 1'b0;

         if (i_done) begin
            regs.start    <= 1'b0;
            regs.intr_sts <= 1'b1;
         end

         case (state)
            st_idle: begin
               if (i_psel && i_penable && i_pwrite) begin
                  state    <= st_write;
                  o_pready <= 1'b1;
               end else if (i_psel && !i_pwrite) begin
                  state <= st_read;         // setup phase of a read
               end
            end
            st_write: begin
               o_pready <= 1'b0;
               state    <= st_idle;
               case (i_paddr)
                  7'h00: {regs.incontrol, regs.start} <= i_pwdata[1:0];
                  7'h01: regs.width       <= i_pwdata[8:0];
                  7'h02: regs.height      <= i_pwdata[8:0];
                  7'h03: regs.channels    <= i_pwdata[8:0];
                  7'h04: regs.filters     <= i_pwdata[8:0];
                  7'h05: regs.filter_base <= i_pwdata[AW-1:0];
                  7'h06: regs.pixel_base  <= i_pwdata[AW-1:0];
                  7'h07: regs.bias_base   <= i_pwdata[AW-1:0];
                  7'h08: regs.result_base <= i_pwdata[AW-1:0];
                  7'h09: regs.total       <= i_pwdata[15:0];
                  7'h0a: regs.intr_en     <= i_pwdata[0];
                  7'h0b: regs.intr_sts    <= i_pwdata[0];
                  7'h0c: ptr              <= i_pwdata[AW-1:0];
                  7'h0d: begin              // pixel window
                     o_pix_wr <= '{we: 1'b1, addr: ptr, data: i_pwdata};
                     ptr      <= ptr + 1'b1;
                  end
                  7'h0e: begin              // coefficient window
                     o_coef_wr <= '{we: 1'b1, addr: ptr, data: i_pwdata};
                     ptr       <= ptr + 1'b1;
                  end
                  7'h10: regs.debug_mux   <= i_pwdata[7:0];
                  7'h12: regs.quant.raw   <= {13'h0, i_pwdata[18:0]};
                  7'h13: {regs.scl, regs.sda} <= i_pwdata[1:0];
                  default: ;
               endcase
            end
            st_read: begin
               o_pready <= 1'b1;
               state    <= st_wait;
               case (i_paddr)
                  7'h00: o_prdata <= {30'h0, regs.incontrol, regs.start};
                  7'h01: o_prdata <= 32'(regs.width);
                  7'h02: o_prdata <= 32'(regs.height);
                  7'h03: o_prdata <= 32'(regs.channels);
                  7'h04: o_prdata <= 32'(regs.filters);
                  7'h05: o_prdata <= 32'(regs.filter_base);
                  7'h06: o_prdata <= 32'(regs.pixel_base);
                  7'h07: o_prdata <= 32'(regs.bias_base);
                  7'h08: o_prdata <= 32'(regs.result_base);
                  7'h09: o_prdata <= 32'(regs.total);
                  7'h0a: o_prdata <= 32'(regs.intr_en);
                  7'h0b: o_prdata <= 32'(regs.intr_sts);
                  7'h0c: o_prdata <= 32'(ptr);
                  7'h0d: begin
                     o_prdata <= i_pix_rdata;
                     ptr      <= ptr + 1'b1;
                  end
                  7'h0e: begin
                     o_prdata <= i_coef_rdata;
                     ptr      <= ptr + 1'b1;
                  end
                  7'h0f: begin              // result window, read only
                     o_prdata <= i_res_rdata;
                     ptr      <= ptr + 1'b1;
                  end
                  7'h10: o_prdata <= 32'(regs.debug_mux);
                  7'h11: o_prdata <= 32'(cycles);
                  7'h12: o_prdata <= regs.quant.raw;
                  7'h13: o_prdata <= {28'h0, regs.scl, regs.sda, i_r_scl, i_r_sda};
                  default: o_prdata <= '0;
               endcase
            end
            st_wait: begin
               o_pready <= 1'b0;
               state    <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

//--- design/cnn_conv_pkg.sv
`include "cnn_config.svh"

package cnn_conv_pkg;

   typedef struct packed {
      logic [8:0]             width;
      logic [8:0]             height;
      logic [8:0]             filters;
      logic [`CNN_ADDR_W-1:0] filter_base;
      logic [`CNN_ADDR_W-1:0] pixel_base;
      logic [`CNN_ADDR_W-1:0] bias_base;
      logic [`CNN_ADDR_W-1:0] result_base;
      logic [15:0]            scale;
      logic [2:0]             shift;
   } conv_cfg_t;

   typedef struct packed {
      logic                   re;
      logic [`CNN_ADDR_W-1:0] addr;
   } eng_rd_t;

   typedef struct packed {
      logic                   we;
      logic [`CNN_ADDR_W-1:0] addr;
      logic [7:0]             data;
   } res_wr_t;

endpackage

//--- design/cnn_reg_pkg.sv
`include "cnn_config.svh"

package cnn_reg_pkg;

   typedef struct packed {
      logic [12:0] rsvd;
      logic [2:0]  shift;
      logic [15:0] scale;   // unsigned, CNN_QFRAC fraction bits
   } quant_fields_t;

   // one bus word, also read as scale and shift
   typedef union packed {
      logic [31:0]   raw;
      quant_fields_t fld;
   } quant_word_u;

   typedef struct packed {
      logic                   start;
      logic                   incontrol;
      logic [8:0]             width;
      logic [8:0]             height;
      logic [8:0]             channels;   // stored only
      logic [8:0]             filters;
      logic [`CNN_ADDR_W-1:0] filter_base;
      logic [`CNN_ADDR_W-1:0] pixel_base;
      logic [`CNN_ADDR_W-1:0] bias_base;
      logic [`CNN_ADDR_W-1:0] result_base;
      logic [15:0]            total;
      logic                   intr_en;
      logic                   intr_sts;
      logic [7:0]             debug_mux;
      quant_word_u            quant;
      logic                   sda;
      logic                   scl;
   } reg_file_t;

   typedef struct packed {
      logic                   we;
      logic [`CNN_ADDR_W-1:0] addr;
      logic [31:0]            data;
   } buf_wr_t;

endpackage

//--- design/cnn_config.svh
`ifndef CNN_CONFIG_SVH
`define CNN_CONFIG_SVH

// buffer addresses are word indices
`define CNN_ADDR_W      12

`define CNN_PIX_DEPTH   4096
`define CNN_COEF_DEPTH  4096
`define CNN_RES_DEPTH   4096

// scale is Q2.14
`define CNN_QFRAC       14

`endif
